// ==== AxiWriteIssuer.sv ====
module AxiWriteIssuer
(
    input  logic                                       aclk,
    input  logic                                       resetn,

    input  logic [FramebufferPkg::AddrWidth - 1 : 0]   confAddr,

    input  logic                                       lineReq,
    input  logic [FramebufferPkg::AddrWidth - 1 : 0]   lineAddr,
    input  logic [FramebufferPkg::StreamWidth - 1 : 0] lineData,
    input  logic [FramebufferPkg::StrbWidth - 1 : 0]   lineStrb,
    output logic                                       lineTaken,

    output logic [FramebufferPkg::IdWidth - 1 : 0]     memAwid,
    output logic [FramebufferPkg::AddrWidth - 1 : 0]   memAwaddr,
    output logic [7:0]                                 memAwlen,
    output logic [2:0]                                 memAwsize,
    output logic [1:0]                                 memAwburst,
    output logic                                       memAwvalid,
    input  logic                                       memAwready,

    output logic [FramebufferPkg::StreamWidth - 1 : 0] memWdata,
    output logic [FramebufferPkg::StrbWidth - 1 : 0]   memWstrb,
    output logic                                       memWlast,
    output logic                                       memWvalid,
    input  logic                                       memWready,

    input  logic [FramebufferPkg::IdWidth - 1 : 0]     memBid,
    input  logic [1:0]                                 memBresp,
    input  logic                                       memBvalid,
    output logic                                       memBready
);
    import FramebufferPkg::*;

    logic channelsIdle;

    // A take is in flight until both valids have risen
    assign channelsIdle = !memAwvalid && !memWvalid && !lineTaken;

    // Every write is a single full-width beat
    assign memAwlen = 8'd0;
    assign memAwsize = 3'(LineByteShift);
    assign memAwburst = Incr;
    assign memWlast = 1'b1;

    // Responses are swallowed as they arrive
    assign memBready = 1'b1;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            lineTaken <= 1'b0;
            memAwid <= '0;
            memAwvalid <= 1'b0;
            memWvalid <= 1'b0;
        end
        else
        begin
            lineTaken <= 1'b0;
            if (channelsIdle && lineReq)
            begin
                lineTaken <= 1'b1;
                memAwid <= memAwid + 1'b1;
                memAwaddr <= confAddr + lineAddr;
                memWdata <= lineData;
                memWstrb <= lineStrb;
            end

            if (lineTaken)
            begin
                memAwvalid <= 1'b1;
                memWvalid <= 1'b1;
            end

            // Address and data beats complete independently
            if (memAwvalid && memAwready)
            begin
                memAwvalid <= 1'b0;
            end
            if (memWvalid && memWready)
            begin
                memWvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== FragmentLineCoalescer.sv ====
module FragmentLineCoalescer
(
    input  logic                                          aclk,
    input  logic                                          resetn,

    input  logic                                          confEnableScissor,
    input  logic [FramebufferPkg::XBitWidth - 1 : 0]      confScissorStartX,
    input  logic [FramebufferPkg::YBitWidth - 1 : 0]      confScissorStartY,
    input  logic [FramebufferPkg::XBitWidth - 1 : 0]      confScissorEndX,
    input  logic [FramebufferPkg::YBitWidth - 1 : 0]      confScissorEndY,
    input  logic [FramebufferPkg::PixelMaskWidth - 1 : 0] confMask,

    input  logic                                          fragValid,
    output logic                                          fragReady,
    input  logic                                          fragLast,
    input  logic [FramebufferPkg::PixelWidth - 1 : 0]     fragData,
    input  logic                                          fragStrb,
    input  logic [FramebufferPkg::AddrWidth - 1 : 0]      fragAddr,
    input  logic [FramebufferPkg::XBitWidth - 1 : 0]      fragXPos,
    input  logic [FramebufferPkg::YBitWidth - 1 : 0]      fragYPos,

    output logic                                          lineReq,
    output logic [FramebufferPkg::AddrWidth - 1 : 0]      lineAddr,
    output logic [FramebufferPkg::StreamWidth - 1 : 0]    lineData,
    output logic [FramebufferPkg::StrbWidth - 1 : 0]      lineStrb,
    input  logic                                          lineTaken
);
    import FramebufferPkg::*;

    CoalescerState                 state;

    // Line that is currently being filled
    logic [IndexTagWidth - 1 : 0]  openTag;
    logic [StreamWidth - 1 : 0]    openData;
    logic [StrbWidth - 1 : 0]      openStrb;
    logic                          openHasData;
    logic                          openLast;
    logic [AddrWidth - 1 : 0]      openLineAddr;

    // One fragment parked while the previous line waits for the issuer
    logic [IndexTagWidth - 1 : 0]  skidTag;
    logic [IndexByteWidth - 1 : 0] skidSlot;
    logic [PixelWidth - 1 : 0]     skidPixel;
    logic [StrbWidth - 1 : 0]      skidStrb;
    logic                          skidLast;

    logic [IndexTagWidth - 1 : 0]  fragTag;
    logic [IndexByteWidth - 1 : 0] fragSlot;
    logic [PixelMaskWidth - 1 : 0] fragMask;
    logic [StrbWidth - 1 : 0]      fragStrobe;
    logic [StreamWidth - 1 : 0]    fragLineData;

    assign fragTag = fragAddr[IndexTagPos +: IndexTagWidth];
    assign fragSlot = fragAddr[IndexBytePos +: IndexByteWidth];
    assign openLineAddr = AddrWidth'(openTag) << LineByteShift;
    assign fragReady = (state == Accepting);

    // Pixel copied into every slot, the strobe picks the lanes that change
    assign fragLineData = {(StreamWidth / PixelWidth){fragData}};

    // Scissor and fragment strobe gate the colour mask as a whole
    assign fragMask = (scissorPass(confEnableScissor, confScissorStartX, confScissorStartY,
                                   confScissorEndX, confScissorEndY, fragXPos, fragYPos)
                       && fragStrb) ? confMask : '0;

    FramebufferWriterStrobeGen strobeGen
    (
        .mask(fragMask),
        .slot(fragSlot),
        .strobe(fragStrobe)
    );

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= Accepting;
            lineReq <= 1'b0;
            openTag <= '0;
            openStrb <= '0;
            openHasData <= 1'b0;
            openLast <= 1'b0;
        end
        else
        begin
            if (lineTaken)
            begin
                lineReq <= 1'b0;
            end

            //////////////////////////////////////////////////////////////
            // Accepting fragments
            //////////////////////////////////////////////////////////////
            if (state == Accepting)
            begin
                if (fragValid)
                begin
                    if ((fragTag == openTag) || !lineReq)
                    begin
                        if (fragTag != openTag)
                        begin
                            // Old line leaves, this fragment opens the next one
                            lineReq <= openHasData;
                            lineAddr <= openLineAddr;
                            lineData <= openData;
                            lineStrb <= openStrb;
                            openTag <= fragTag;
                            openStrb <= fragStrobe;
                        end
                        else
                        begin
                            openStrb <= openStrb | fragStrobe;
                        end
                        // Masked bytes keep what earlier fragments wrote
                        for (int lane = 0; lane < StrbWidth; lane++)
                        begin
                            if (fragStrobe[lane])
                            begin
                                openData[lane * 8 +: 8] <= fragLineData[lane * 8 +: 8];
                            end
                        end
                        openHasData <= 1'b1;
                        if (fragLast)
                        begin
                            openLast <= 1'b1;
                            state <= Draining;
                        end
                    end
                    else
                    begin
                        // Issuer still busy with the previous line
                        skidTag <= fragTag;
                        skidSlot <= fragSlot;
                        skidPixel <= fragData;
                        skidStrb <= fragStrobe;
                        skidLast <= fragLast;
                        state <= Draining;
                    end
                end
            end

            //////////////////////////////////////////////////////////////
            // Draining once the request slot is free
            //////////////////////////////////////////////////////////////
            else if (!lineReq)
            begin
                lineReq <= openHasData;
                lineAddr <= openLineAddr;
                lineData <= openData;
                lineStrb <= openStrb;
                if (openLast)
                begin
                    // End of stream, next stream starts from an empty line
                    openTag <= '0;
                    openStrb <= '0;
                    openHasData <= 1'b0;
                    openLast <= 1'b0;
                    state <= Accepting;
                end
                else
                begin
                    openTag <= skidTag;
                    openData[skidSlot * PixelWidth +: PixelWidth] <= skidPixel;
                    openStrb <= skidStrb;
                    openHasData <= 1'b1;
                    openLast <= skidLast;
                    // A parked last fragment needs one more drain
                    if (!skidLast)
                    begin
                        state <= Accepting;
                    end
                end
            end
        end
    end

endmodule

// ==== FramebufferPkg.sv ====
package FramebufferPkg;

    //////////////////////////////////////////////////////////////////////
    // Bus and pixel geometry
    //////////////////////////////////////////////////////////////////////

    localparam int StreamWidth = 32;
    localparam int AddrWidth = 32;
    localparam int StrbWidth = StreamWidth / 8;
    localparam int IdWidth = 8;

    // Largest screen is 2048 x 2048
    localparam int XBitWidth = 11;
    localparam int YBitWidth = 11;

    localparam int PixelWidth = 16;
    localparam int PixelMaskWidth = PixelWidth / 8;

    // A pixel address splits into a slot inside the line and the line tag
    localparam int IndexBytePos = 0;
    localparam int IndexByteWidth = $clog2(StreamWidth / PixelWidth);
    localparam int IndexTagPos = IndexByteWidth;
    localparam int IndexTagWidth = AddrWidth - IndexTagPos;

    // Tag to byte address of a line
    localparam int LineByteShift = $clog2(StrbWidth);

    typedef enum logic
    {
        Accepting,
        Draining
    } CoalescerState;

    // Encoding of awburst
    typedef enum logic [1:0]
    {
        Fixed = 2'd0,
        Incr  = 2'd1,
        Wrap  = 2'd2
    } BurstType;

    function automatic logic scissorPass(
        input logic                     enable,
        input logic [XBitWidth - 1 : 0] startX,
        input logic [YBitWidth - 1 : 0] startY,
        input logic [XBitWidth - 1 : 0] endX,
        input logic [YBitWidth - 1 : 0] endY,
        input logic [XBitWidth - 1 : 0] x,
        input logic [YBitWidth - 1 : 0] y
    );
        return !enable || ((x >= startX) && (x < endX) && (y >= startY) && (y < endY));
    endfunction

endpackage

// ==== FramebufferWriter.f ====
FramebufferPkg.sv
FramebufferWriterStrobeGen.sv
FragmentLineCoalescer.sv
AxiWriteIssuer.sv
FramebufferWriter.sv
FramebufferWriter_properties.sv
FramebufferWriterTb.sv

// ==== FramebufferWriter.sv ====
module FramebufferWriter
(
    input  logic                                          aclk,
    input  logic                                          resetn,

    //////////////////////////////////////////////////////////////////////
    // Configuration
    //////////////////////////////////////////////////////////////////////
    input  logic [FramebufferPkg::AddrWidth - 1 : 0]      confAddr,
    input  logic                                          confEnableScissor,
    input  logic [FramebufferPkg::XBitWidth - 1 : 0]      confScissorStartX,
    input  logic [FramebufferPkg::YBitWidth - 1 : 0]      confScissorStartY,
    input  logic [FramebufferPkg::XBitWidth - 1 : 0]      confScissorEndX,
    input  logic [FramebufferPkg::YBitWidth - 1 : 0]      confScissorEndY,
    input  logic [FramebufferPkg::PixelMaskWidth - 1 : 0] confMask,

    //////////////////////////////////////////////////////////////////////
    // Fragment stream
    //////////////////////////////////////////////////////////////////////
    input  logic                                          fragValid,
    output logic                                          fragReady,
    input  logic                                          fragLast,
    input  logic [FramebufferPkg::PixelWidth - 1 : 0]     fragData,
    input  logic                                          fragStrb,
    input  logic [FramebufferPkg::AddrWidth - 1 : 0]      fragAddr,
    input  logic [FramebufferPkg::XBitWidth - 1 : 0]      fragXPos,
    input  logic [FramebufferPkg::YBitWidth - 1 : 0]      fragYPos,

    //////////////////////////////////////////////////////////////////////
    // Memory write channels
    //////////////////////////////////////////////////////////////////////
    output logic [FramebufferPkg::IdWidth - 1 : 0]        memAwid,
    output logic [FramebufferPkg::AddrWidth - 1 : 0]      memAwaddr,
    output logic [7:0]                                    memAwlen,
    output logic [2:0]                                    memAwsize,
    output logic [1:0]                                    memAwburst,
    output logic                                          memAwvalid,
    input  logic                                          memAwready,

    output logic [FramebufferPkg::StreamWidth - 1 : 0]    memWdata,
    output logic [FramebufferPkg::StrbWidth - 1 : 0]      memWstrb,
    output logic                                          memWlast,
    output logic                                          memWvalid,
    input  logic                                          memWready,

    input  logic [FramebufferPkg::IdWidth - 1 : 0]        memBid,
    input  logic [1:0]                                    memBresp,
    input  logic                                          memBvalid,
    output logic                                          memBready
);
    import FramebufferPkg::*;

    // Finished line on its way from the coalescer to the issuer
    logic                       lineReq;
    logic [AddrWidth - 1 : 0]   lineAddr;
    logic [StreamWidth - 1 : 0] lineData;
    logic [StrbWidth - 1 : 0]   lineStrb;
    logic                       lineTaken;

    FragmentLineCoalescer coalescer
    (
        .*
    );

    AxiWriteIssuer issuer
    (
        .*
    );

endmodule

// ==== FramebufferWriterStrobeGen.sv ====
module FramebufferWriterStrobeGen
(
    input  logic [FramebufferPkg::PixelMaskWidth - 1 : 0] mask,
    input  logic [FramebufferPkg::IndexByteWidth - 1 : 0] slot,
    output logic [FramebufferPkg::StrbWidth - 1 : 0]      strobe
);
    import FramebufferPkg::*;

    // Each pixel slot owns PixelMaskWidth neighbouring byte lanes
    always_comb
    begin
        strobe = '0;
        strobe[slot * PixelMaskWidth +: PixelMaskWidth] = mask;
    end

endmodule

// ==== FramebufferWriterTb.sv ====
module FramebufferWriterTb;
    timeunit 1ns;
    timeprecision 1ps;
    import FramebufferPkg::*;

    localparam logic [31:0] BaseAddr = 32'h1000_0000;
    localparam int TimeoutCycles = 2000;

    typedef struct packed
    {
        logic [31:0] addr;
        logic [15:0] data;
        logic        strb;
        logic [10:0] x;
        logic [10:0] y;
        logic        scissorOn;
        logic [10:0] startX;
        logic [10:0] startY;
        logic [10:0] endX;
        logic [10:0] endY;
        logic [1:0]  mask;
        logic        first;
    } Fragment;

    logic aclk, resetn;
    logic [31:0] confAddr;
    logic confEnableScissor;
    logic [10:0] confScissorStartX, confScissorStartY, confScissorEndX, confScissorEndY;
    logic [1:0] confMask;
    logic fragValid, fragReady, fragLast, fragStrb;
    logic [15:0] fragData;
    logic [31:0] fragAddr;
    logic [10:0] fragXPos, fragYPos;
    logic [7:0] memAwid, memAwlen, memBid;
    logic [31:0] memAwaddr, memWdata;
    logic [2:0] memAwsize;
    logic [1:0] memAwburst, memBresp;
    logic memAwvalid, memAwready, memWlast, memWvalid, memWready, memBvalid, memBready;
    logic [3:0] memWstrb;

    // Sparse memory behind the write channels and everything it has seen
    logic [7:0] memory [logic [31:0]];
    logic [31:0] awAddrQ[$], wDataQ[$], seenAddr[$];
    logic [7:0] awIdQ[$], seenId[$];
    logic [3:0] wStrbQ[$], seenStrb[$];
    logic stallEnable;

    // Reference state
    Fragment sent[$];
    logic [7:0] expBytes [logic [31:0]];
    logic [31:0] expAddr[$];
    logic [3:0] expStrb[$];
    logic streamStart;
    string testName;

    FramebufferWriter UUT (.*);

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    always @(posedge aclk)
    begin : memoryModel
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] strb;
        if (resetn)
        begin
            if (memAwvalid && memAwready)
            begin
                // Single-beat incrementing write of one full word
                checkEqual({testName, " awlen"}, 32'd0, 32'(memAwlen));
                checkEqual({testName, " awsize"}, 32'd2, 32'(memAwsize));
                checkEqual({testName, " awburst"}, 32'(Incr), 32'(memAwburst));
                awAddrQ.push_back(memAwaddr);
                awIdQ.push_back(memAwid);
            end
            if (memWvalid && memWready)
            begin
                wDataQ.push_back(memWdata);
                wStrbQ.push_back(memWstrb);
            end
            while (awAddrQ.size() > 0 && wDataQ.size() > 0)
            begin
                addr = awAddrQ.pop_front();
                data = wDataQ.pop_front();
                strb = wStrbQ.pop_front();
                seenAddr.push_back(addr);
                seenStrb.push_back(strb);
                seenId.push_back(awIdQ.pop_front());
                for (int lane = 0; lane < 4; lane++)
                begin
                    if (strb[lane])
                    begin
                        memory[addr + 32'(lane)] = data[lane * 8 +: 8];
                    end
                end
            end
        end
    end

    // Ready stalls change a little after each edge
    initial
    begin
        forever
        begin
            @(posedge aclk);
            #2;
            memAwready = !stallEnable || ($urandom % 3 != 0);
            memWready = !stallEnable || ($urandom % 3 != 0);
        end
    end

    task automatic checkEqual(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout in %s while waiting for %s", testName, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // Replays every sent fragment into expected bytes and expected writes
    function automatic void expectedMemory();
        Fragment f;
        logic [31:0] tag;
        logic [31:0] prevTag;
        logic pass;
        expBytes.delete();
        expAddr.delete();
        expStrb.delete();
        prevTag = '0;
        foreach (sent[i])
        begin
            f = sent[i];
            tag = f.addr >> 1;
            if (f.first || tag != prevTag)
            begin
                expAddr.push_back(BaseAddr + (tag << 2));
                expStrb.push_back(4'b0);
            end
            prevTag = tag;
            pass = scissorPass(f.scissorOn, f.startX, f.startY, f.endX, f.endY, f.x, f.y);
            for (int b = 0; b < 2; b++)
            begin
                if (pass && f.strb && f.mask[b])
                begin
                    expBytes[BaseAddr + (f.addr << 1) + 32'(b)] = f.data[b * 8 +: 8];
                    expStrb[expStrb.size() - 1][f.addr[0] * 2 + b] = 1'b1;
                end
            end
        end
    endfunction

    task automatic sendFragment(input logic [31:0] addr, input logic [15:0] data,
                                input logic strb, input logic [10:0] x,
                                input logic [10:0] y, input logic last);
        logic accepted;
        int cycles;
        sent.push_back({addr, data, strb, x, y, confEnableScissor, confScissorStartX,
                        confScissorStartY, confScissorEndX, confScissorEndY, confMask,
                        streamStart});
        streamStart = 1'b0;
        fragAddr = addr;
        fragData = data;
        fragStrb = strb;
        fragXPos = x;
        fragYPos = y;
        fragLast = last;
        fragValid = 1'b1;
        cycles = 0;
        do
        begin
            accepted = fragReady;
            @(posedge aclk);
            #2;
            cycles++;
            if (cycles > TimeoutCycles)
            begin
                reportTimeout("fragReady");
            end
        end
        while (!accepted);
        fragValid = 1'b0;
        fragLast = 1'b0;
    endtask

    // Waits for the flush to finish and all writes to land, then compares
    task automatic finishStream();
        int cycles;
        cycles = 0;
        while (!fragReady)
        begin
            @(posedge aclk);
            #2;
            cycles++;
            if (cycles > TimeoutCycles)
            begin
                reportTimeout("fragReady after the last fragment");
            end
        end
        expectedMemory();
        cycles = 0;
        while (seenAddr.size() < expAddr.size())
        begin
            @(posedge aclk);
            #2;
            cycles++;
            if (cycles > TimeoutCycles)
            begin
                reportTimeout("memory writes");
            end
        end
        checkEqual({testName, " write count"}, 32'(expAddr.size()), 32'(seenAddr.size()));
        foreach (expAddr[n])
        begin
            checkEqual({testName, " awaddr"}, expAddr[n], seenAddr[n]);
            checkEqual({testName, " wstrb"}, 32'(expStrb[n]), 32'(seenStrb[n]));
            checkEqual({testName, " awid"}, 32'(8'(n + 1)), 32'(seenId[n]));
        end
        checkEqual({testName, " byte count"}, 32'(expBytes.size()), 32'(memory.size()));
        foreach (memory[a])
        begin
            checkEqual({testName, " byte present"}, 32'd1, 32'(expBytes.exists(a)));
            checkEqual({testName, " byte value"}, 32'(expBytes[a]), 32'(memory[a]));
        end
        streamStart = 1'b1;
    endtask

    initial
    begin
        logic [31:0] addr;
        void'($urandom(32'h82c6_5b27));
        resetn = 1'b0;
        confAddr = BaseAddr;
        confEnableScissor = 1'b0;
        confScissorStartX = 11'd2;
        confScissorStartY = 11'd1;
        confScissorEndX = 11'd6;
        confScissorEndY = 11'd3;
        confMask = 2'b11;
        fragValid = 1'b0;
        fragLast = 1'b0;
        fragData = '0;
        fragStrb = 1'b0;
        fragAddr = '0;
        fragXPos = '0;
        fragYPos = '0;
        memBid = '0;
        memBresp = '0;
        memBvalid = 1'b0;
        memAwready = 1'b1;
        memWready = 1'b1;
        stallEnable = 1'b0;
        streamStart = 1'b1;
        repeat (4) @(posedge aclk);
        #2;
        resetn = 1'b1;

        testName = "merge";
        for (int i = 0; i < 11; i++)
        begin
            sendFragment(32'h100 + 32'(i), 16'(16'ha000 + i), 1'b1, 11'd0, 11'd0, i == 10);
        end
        finishStream();

        testName = "scissor";
        confEnableScissor = 1'b1;
        for (int i = 0; i < 32; i++)
        begin
            sendFragment(32'h200 + 32'(i), 16'($urandom), 1'b1, 11'(i % 8), 11'(i / 8),
                         i == 31);
        end
        finishStream();
        confEnableScissor = 1'b0;
        for (int i = 0; i < 8; i++)
        begin
            sendFragment(32'h240 + 32'(i), 16'($urandom), 1'b1, 11'd9, 11'd9, i == 7);
        end
        finishStream();

        testName = "mask";
        for (int m = 1; m < 3; m++)
        begin
            confMask = 2'(m);
            for (int i = 0; i < 10; i++)
            begin
                sendFragment(32'h280 + 32'(i), 16'($urandom), 1'(i % 3 != 1), 11'd0, 11'd0,
                             i == 9);
            end
            finishStream();
        end
        confMask = 2'b11;

        testName = "stall";
        stallEnable = 1'b1;
        addr = 32'h400;
        for (int i = 0; i < 60; i++)
        begin
            addr = addr + 32'($urandom_range(0, 2));
            sendFragment(addr, 16'($urandom), 1'($urandom % 5 != 0), 11'd0, 11'd0, i == 59);
        end
        finishStream();

        testName = "flush";
        sendFragment(32'h0, 16'h1111, 1'b1, 11'd0, 11'd0, 1'b0);
        sendFragment(32'h1, 16'h2222, 1'b1, 11'd0, 11'd0, 1'b1);
        finishStream();
        // Each stream starts on the line tag where the previous one ended
        for (int s = 0; s < 3; s++)
        begin
            for (int i = 0; i < 4; i++)
            begin
                sendFragment(32'h302 + 32'(2 * s + i), 16'($urandom), 1'b1, 11'd0, 11'd0,
                             i == 3);
            end
            finishStream();
        end
        stallEnable = 1'b0;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== FramebufferWriter_properties.sv ====
module FramebufferWriterProperties
(
    input logic aclk,
    input logic resetn,
    input logic memAwvalid,
    input logic memAwready,
    input logic memWvalid,
    input logic memWready,
    input logic memWlast,
    input logic memBready,
    input logic fragReady,
    input logic lineReq
);
    timeunit 1ns;
    timeprecision 1ps;

    // Valid may only fall after its ready
    awHold: assert property (@(posedge aclk) disable iff (!resetn)
        memAwvalid && !memAwready |=> memAwvalid)
        else $error("awvalid dropped before awready");

    wHold: assert property (@(posedge aclk) disable iff (!resetn)
        memWvalid && !memWready |=> memWvalid)
        else $error("wvalid dropped before wready");

    // First cycle out of reset
    resetValues: assert property (@(posedge aclk)
        $rose(resetn) |-> !memAwvalid && !memWvalid && !lineReq && memBready && fragReady)
        else $error("wrong values after reset");

    lastAlways: assert property (@(posedge aclk) disable iff (!resetn) memWlast)
        else $error("wlast low");

endmodule

bind FramebufferWriter FramebufferWriterProperties properties (.*);

// ==== Makefile ====
SOURCES = $(shell cat FramebufferWriter.f)

.PHONY: all run clean

all: run

obj_dir/VFramebufferWriterTb: FramebufferWriter.f $(SOURCES)
	verilator --binary --timing --assert --top-module FramebufferWriterTb \
		-f FramebufferWriter.f -o VFramebufferWriterTb

run: obj_dir/VFramebufferWriterTb
	-./obj_dir/VFramebufferWriterTb > sim.log 2>&1
	cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
